// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= mem_complex_tb
RTL_TOP    ?= mem_complex
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard include/*.svh src/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/mc_consts.svh ====
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// ------------------------------
// memory complex geometry
// ------------------------------

// number of columns in the row, one l2 slice per column.
`define MC_X_DIM 4

// word address width and data word width.
`define MC_ADDR_WIDTH 16
`define MC_DATA_WIDTH 32

// each slice is direct mapped with one word per line.
`define MC_SETS_LOG2 4
`define MC_SETS (1 << `MC_SETS_LOG2)

// the tag keeps every address bit above the set index.
`define MC_TAG_WIDTH (`MC_ADDR_WIDTH - `MC_SETS_LOG2)

`endif

// ==== sim.f ====
+incdir+include
src/mc_pkg.sv
src/mc_req_if.sv
src/l2_data_ram.sv
src/l2_cache_slice.sv
src/mem_complex.sv
verif/mem_complex_tb.sv

// ==== src/l2_cache_slice.sv ====
`include "mc_consts.svh"

module l2_cache_slice
  (input                        core_clk_i
   , input                      reset_i

   , mc_req_if.receiver         coh_req

   , output logic               resp_v_o
   , output mc_pkg::mc_resp_e   resp_op_o
   , output mc_pkg::mc_data_t   resp_data_o

   , mc_req_if.sender           mem_req
   , input                      mem_resp_v_i
   , input mc_pkg::mc_data_t    mem_resp_data_i
   );

  mc_pkg::mc_slice_state_e state_r, state_n;

  // request held from the strobe until the response leaves.
  mc_pkg::mc_op_e    req_op_r;
  mc_pkg::mc_addr_t  req_addr_r;
  mc_pkg::mc_data_t  req_data_r;
  mc_pkg::mc_index_t req_index;
  mc_pkg::mc_tag_t   req_tag;

  logic [`MC_SETS-1:0] valid_r;
  logic                mem_req_v_r;
  mc_pkg::mc_data_t    resp_data_r;

  mc_pkg::mc_index_t ram_addr_li;
  mc_pkg::mc_tag_t   tag_r_data_lo;
  mc_pkg::mc_data_t  data_r_data_lo;
  mc_pkg::mc_data_t  data_w_data_li;
  logic              tag_w_v_li;
  logic              data_w_v_li;

  logic hit;
  logic is_write;

  assign req_index = mc_pkg::mc_addr_index(req_addr_r);
  assign req_tag   = mc_pkg::mc_addr_tag(req_addr_r);
  assign is_write  = (req_op_r == mc_pkg::e_op_write);

  // ------------------------------
  // tag and data storage
  // ------------------------------

  // while idle the rams are read at the incoming index, so tag and data
  // are ready the cycle the slice enters lookup.
  assign ram_addr_li = (state_r == mc_pkg::e_idle)
                       ? mc_pkg::mc_addr_index(coh_req.addr)
                       : req_index;

  assign tag_w_v_li  = (state_r == mc_pkg::e_fill_write);

  // write-through with no allocate. a write only touches a present line.
  assign data_w_v_li = tag_w_v_li
                       | ((state_r == mc_pkg::e_lookup) & is_write & hit);
  assign data_w_data_li = tag_w_v_li ? resp_data_r : req_data_r;

  l2_data_ram
   #(.width_p(`MC_TAG_WIDTH)
     ,.els_p(`MC_SETS)
     )
   tag_ram
    (.clk_i(core_clk_i)
     ,.w_v_i(tag_w_v_li)
     ,.addr_i(ram_addr_li)
     ,.w_data_i(req_tag)
     ,.r_data_o(tag_r_data_lo)
     );

  l2_data_ram
   #(.width_p(`MC_DATA_WIDTH)
     ,.els_p(`MC_SETS)
     )
   data_ram
    (.clk_i(core_clk_i)
     ,.w_v_i(data_w_v_li)
     ,.addr_i(ram_addr_li)
     ,.w_data_i(data_w_data_li)
     ,.r_data_o(data_r_data_lo)
     );

  assign hit = valid_r[req_index] & (tag_r_data_lo == req_tag);

  // ------------------------------
  // control
  // ------------------------------

  always_comb
    begin
      state_n = state_r;
      case (state_r)
        mc_pkg::e_idle:
          if (coh_req.v)
            state_n = mc_pkg::e_lookup;
        mc_pkg::e_lookup:
          state_n = (!is_write && !hit) ? mc_pkg::e_fill_wait : mc_pkg::e_respond;
        mc_pkg::e_fill_wait:
          if (mem_resp_v_i)
            state_n = mc_pkg::e_fill_write;
        mc_pkg::e_fill_write:
          state_n = mc_pkg::e_respond;
        mc_pkg::e_respond:
          state_n = mc_pkg::e_idle;
        default:
          state_n = mc_pkg::e_idle;
      endcase
    end

  always_ff @(posedge core_clk_i)
    begin
      if (reset_i)
        begin
          state_r     <= mc_pkg::e_idle;
          valid_r     <= '0;
          mem_req_v_r <= 1'b0;
        end
      else
        begin
          state_r <= state_n;
          // misses and all writes go south one cycle after lookup.
          mem_req_v_r <= (state_r == mc_pkg::e_lookup) & (is_write | ~hit);
          if (tag_w_v_li)
            valid_r[req_index] <= 1'b1;
        end
    end

  always_ff @(posedge core_clk_i)
    begin
      if ((state_r == mc_pkg::e_idle) && coh_req.v)
        begin
          req_op_r   <= coh_req.op;
          req_addr_r <= coh_req.addr;
          req_data_r <= coh_req.data;
        end

      // a miss overwrites this again when the fill returns.
      if (state_r == mc_pkg::e_lookup)
        resp_data_r <= is_write ? req_data_r : data_r_data_lo;
      else if ((state_r == mc_pkg::e_fill_wait) && mem_resp_v_i)
        resp_data_r <= mem_resp_data_i;
    end

  // ------------------------------
  // outputs
  // ------------------------------

  assign resp_v_o    = (state_r == mc_pkg::e_respond);
  assign resp_op_o   = is_write ? mc_pkg::e_resp_ack : mc_pkg::e_resp_data;
  assign resp_data_o = resp_data_r;

  assign mem_req.v    = mem_req_v_r;
  assign mem_req.op   = req_op_r;
  assign mem_req.addr = req_addr_r;
  assign mem_req.data = req_data_r;

  // the requester must wait for the response before the next request.
  busy_req_a :
    assert property (@(posedge core_clk_i) disable iff (reset_i)
      coh_req.v |-> (state_r == mc_pkg::e_idle))
    else $error("request arrived while slice busy");

  unexpected_fill_a :
    assert property (@(posedge core_clk_i) disable iff (reset_i)
      mem_resp_v_i |-> (state_r == mc_pkg::e_fill_wait))
    else $error("memory return with no fill pending");

  // a miss answers only after its fill, never alongside its fetch.
  resp_vs_fetch_a :
    assert property (@(posedge core_clk_i) disable iff (reset_i)
      !(resp_v_o && mem_req.v && (mem_req.op == mc_pkg::e_op_read)))
    else $error("response and memory read in the same cycle");

endmodule

// ==== src/l2_data_ram.sv ====
module l2_data_ram
 #(parameter width_p = 32
   , parameter els_p = 16

   , localparam lg_els_lp = (els_p > 1) ? $clog2(els_p) : 1
   )
  (input                        clk_i

   , input                      w_v_i
   , input [lg_els_lp-1:0]      addr_i
   , input [width_p-1:0]        w_data_i

   , output logic [width_p-1:0] r_data_o
   );

  logic [width_p-1:0] mem_r [els_p];

  // one shared address, read every cycle.
  // a write in the same cycle shows up only on the next read.
  always_ff @(posedge clk_i)
    begin
      if (w_v_i)
        mem_r[addr_i] <= w_data_i;
      r_data_o <= mem_r[addr_i];
    end

endmodule

// ==== src/mc_pkg.sv ====
`include "mc_consts.svh"

package mc_pkg;

  // ------------------------------
  // vector types
  // ------------------------------

  typedef logic [`MC_ADDR_WIDTH-1:0] mc_addr_t;
  typedef logic [`MC_DATA_WIDTH-1:0] mc_data_t;

  // the low address bits pick the line, the rest form the tag.
  typedef logic [`MC_SETS_LOG2-1:0] mc_index_t;
  typedef logic [`MC_TAG_WIDTH-1:0] mc_tag_t;

  // ------------------------------
  // encodings
  // ------------------------------

  typedef enum logic
  {
    e_op_read    = 1'b0
    , e_op_write = 1'b1
  } mc_op_e;

  // reads come back with data, writes with a bare acknowledge.
  typedef enum logic
  {
    e_resp_data  = 1'b0
    , e_resp_ack = 1'b1
  } mc_resp_e;

  typedef enum logic [2:0]
  {
    e_idle         = 3'd0
    , e_lookup     = 3'd1
    , e_fill_wait  = 3'd2
    , e_fill_write = 3'd3
    , e_respond    = 3'd4
  } mc_slice_state_e;

  // ------------------------------
  // address split
  // ------------------------------

  function automatic mc_index_t mc_addr_index(input mc_addr_t addr);
    return addr[`MC_SETS_LOG2-1:0];
  endfunction

  function automatic mc_tag_t mc_addr_tag(input mc_addr_t addr);
    return addr[`MC_ADDR_WIDTH-1:`MC_SETS_LOG2];
  endfunction

endpackage

// ==== src/mc_req_if.sv ====
// one request link, used both for the north side into a slice and
// for the south side toward backing memory.
interface mc_req_if;

  logic             v;
  mc_pkg::mc_op_e   op;
  mc_pkg::mc_addr_t addr;
  mc_pkg::mc_data_t data;

  // the sender raises v for exactly one cycle per request.
  modport sender
    (output v
     , output op
     , output addr
     , output data
     );

  // the receiver has no way to stall and must take v in that cycle.
  modport receiver
    (input v
     , input op
     , input addr
     , input data
     );

endinterface

// ==== src/mem_complex.sv ====
`include "mc_consts.svh"

module mem_complex
  (input                                              core_clk_i
   , input                                            reset_i

   // coherence requests from the north, one link per column.
   , input [`MC_X_DIM-1:0]                            coh_req_v_i
   , input mc_pkg::mc_op_e [`MC_X_DIM-1:0]            coh_req_op_i
   , input mc_pkg::mc_addr_t [`MC_X_DIM-1:0]          coh_req_addr_i
   , input mc_pkg::mc_data_t [`MC_X_DIM-1:0]          coh_req_data_i

   , output logic [`MC_X_DIM-1:0]                     coh_resp_v_o
   , output mc_pkg::mc_resp_e [`MC_X_DIM-1:0]         coh_resp_op_o
   , output mc_pkg::mc_data_t [`MC_X_DIM-1:0]         coh_resp_data_o

   // dma links to backing memory in the south.
   , output logic [`MC_X_DIM-1:0]                     mem_req_v_o
   , output mc_pkg::mc_op_e [`MC_X_DIM-1:0]           mem_req_op_o
   , output mc_pkg::mc_addr_t [`MC_X_DIM-1:0]         mem_req_addr_o
   , output mc_pkg::mc_data_t [`MC_X_DIM-1:0]         mem_req_data_o

   , input [`MC_X_DIM-1:0]                            mem_resp_v_i
   , input mc_pkg::mc_data_t [`MC_X_DIM-1:0]          mem_resp_data_i
   );

  // ------------------------------
  // per column slices
  // ------------------------------

  for (genvar i = 0; i < `MC_X_DIM; i++)
    begin : col
      mc_req_if coh_req ();
      mc_req_if mem_req ();

      assign coh_req.v    = coh_req_v_i[i];
      assign coh_req.op   = coh_req_op_i[i];
      assign coh_req.addr = coh_req_addr_i[i];
      assign coh_req.data = coh_req_data_i[i];

      l2_cache_slice
       slice
        (.core_clk_i(core_clk_i)
         ,.reset_i(reset_i)

         ,.coh_req(coh_req)

         ,.resp_v_o(coh_resp_v_o[i])
         ,.resp_op_o(coh_resp_op_o[i])
         ,.resp_data_o(coh_resp_data_o[i])

         ,.mem_req(mem_req)
         ,.mem_resp_v_i(mem_resp_v_i[i])
         ,.mem_resp_data_i(mem_resp_data_i[i])
         );

      assign mem_req_v_o[i]    = mem_req.v;
      assign mem_req_op_o[i]   = mem_req.op;
      assign mem_req_addr_o[i] = mem_req.addr;
      assign mem_req_data_o[i] = mem_req.data;
    end

endmodule

// ==== verif/mem_complex_tb.sv ====
`include "mc_consts.svh"

module mem_complex_tb;

  localparam int          num_reqs_lp   = 300;
  localparam int          addr_span_lp  = 64;
  localparam int unsigned timeout_lp    = num_reqs_lp * 20 + 200;

  logic core_clk_i;
  logic reset_i;

  logic [`MC_X_DIM-1:0]                     coh_req_v_i;
  mc_pkg::mc_op_e [`MC_X_DIM-1:0]           coh_req_op_i;
  mc_pkg::mc_addr_t [`MC_X_DIM-1:0]         coh_req_addr_i;
  mc_pkg::mc_data_t [`MC_X_DIM-1:0]         coh_req_data_i;
  logic [`MC_X_DIM-1:0]                     coh_resp_v_o;
  mc_pkg::mc_resp_e [`MC_X_DIM-1:0]         coh_resp_op_o;
  mc_pkg::mc_data_t [`MC_X_DIM-1:0]         coh_resp_data_o;
  logic [`MC_X_DIM-1:0]                     mem_req_v_o;
  mc_pkg::mc_op_e [`MC_X_DIM-1:0]           mem_req_op_o;
  mc_pkg::mc_addr_t [`MC_X_DIM-1:0]         mem_req_addr_o;
  mc_pkg::mc_data_t [`MC_X_DIM-1:0]         mem_req_data_o;
  logic [`MC_X_DIM-1:0]                     mem_resp_v_i;
  mc_pkg::mc_data_t [`MC_X_DIM-1:0]         mem_resp_data_i;

  // random traffic for every column, one entry per request.
  mc_pkg::mc_op_e   stim_op    [`MC_X_DIM][num_reqs_lp];
  mc_pkg::mc_addr_t stim_addr  [`MC_X_DIM][num_reqs_lp];
  mc_pkg::mc_data_t stim_data  [`MC_X_DIM][num_reqs_lp];
  int unsigned      stim_delay [`MC_X_DIM][num_reqs_lp];

  // the responder's backing memory, and the model's view of it.
  mc_pkg::mc_data_t backing_mem [`MC_X_DIM][addr_span_lp];
  mc_pkg::mc_data_t shadow_mem  [`MC_X_DIM][addr_span_lp];
  logic             model_valid [`MC_X_DIM][`MC_SETS];
  mc_pkg::mc_tag_t  model_tag   [`MC_X_DIM][`MC_SETS];

  int unsigned cycle_r = 0;
  int          hit_cnt = 0;
  int          miss_cnt = 0;
  int          write_cnt = 0;

  mem_complex UUT
    (.core_clk_i(core_clk_i)
     ,.reset_i(reset_i)
     ,.coh_req_v_i(coh_req_v_i)
     ,.coh_req_op_i(coh_req_op_i)
     ,.coh_req_addr_i(coh_req_addr_i)
     ,.coh_req_data_i(coh_req_data_i)
     ,.coh_resp_v_o(coh_resp_v_o)
     ,.coh_resp_op_o(coh_resp_op_o)
     ,.coh_resp_data_o(coh_resp_data_o)
     ,.mem_req_v_o(mem_req_v_o)
     ,.mem_req_op_o(mem_req_op_o)
     ,.mem_req_addr_o(mem_req_addr_o)
     ,.mem_req_data_o(mem_req_data_o)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     );

  initial
    begin
      core_clk_i = 1'b0;
      forever #4 core_clk_i = ~core_clk_i;
    end

  // ------------------------------
  // reporting and compares
  // ------------------------------

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_data(input int col, input string what,
                            input mc_pkg::mc_data_t got, input mc_pkg::mc_data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error at time %0t: column %0d %s is %h, expected %h",
                              $time, col, what, got, exp));
  endtask

  task automatic check_resp(input int col, input mc_pkg::mc_resp_e got,
                            input mc_pkg::mc_resp_e exp);
    if (got !== exp)
      stop_on_error($sformatf("error at time %0t: column %0d response is %s, expected %s",
                              $time, col, got.name(), exp.name()));
  endtask

  task automatic check_addr(input int col, input mc_pkg::mc_addr_t got,
                            input mc_pkg::mc_addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error at time %0t: column %0d memory address is %h, expected %h",
                              $time, col, got, exp));
  endtask

  task automatic check_op(input int col, input mc_pkg::mc_op_e got, input mc_pkg::mc_op_e exp);
    if (got !== exp)
      stop_on_error($sformatf("error at time %0t: column %0d memory op is %s, expected %s",
                              $time, col, got.name(), exp.name()));
  endtask

  task automatic check_hit(input int col, input bit got, input bit exp);
    if (got !== exp)
      stop_on_error($sformatf("error at time %0t: column %0d read hit is %0b, expected %0b",
                              $time, col, got, exp));
  endtask

  // an idle column must keep both of its outgoing strobes low.
  task automatic expect_quiet(input int col);
    if (mem_req_v_o[col] || coh_resp_v_o[col])
      stop_on_error($sformatf("column %0d raised a strobe at time %0t with no request pending",
                              col, $time));
  endtask

  // every word of backing memory starts with a value tied to its column and address.
  function automatic mc_pkg::mc_data_t fill_word(input int col, input int addr);
    return {8'(col + 1), 8'(addr * 7 + 3), 16'(addr ^ 32'hc3a5)};
  endfunction

  // ------------------------------
  // per column driver and memory
  // ------------------------------

  task automatic run_column(input int col);
    mc_pkg::mc_op_e    op;
    mc_pkg::mc_addr_t  addr;
    mc_pkg::mc_data_t  data;
    mc_pkg::mc_index_t idx;
    mc_pkg::mc_tag_t   tag;
    int unsigned       req_cyc;
    int unsigned       resp_cyc;
    int unsigned       fill_cyc;
    int unsigned       fill_due;
    int unsigned       exp_cyc;
    int                mem_cnt;
    int                exp_mem;
    bit                pending_fill;
    bit                got_resp;
    bit                exp_hit;
    for (int k = 0; k < num_reqs_lp; k++)
      begin
        op   = stim_op[col][k];
        addr = stim_addr[col][k];
        data = stim_data[col][k];
        idx  = addr[`MC_SETS_LOG2-1:0];
        tag  = addr[`MC_ADDR_WIDTH-1:`MC_SETS_LOG2];
        exp_hit = model_valid[col][idx] && (model_tag[col][idx] == tag);

        @(negedge core_clk_i);
        expect_quiet(col);
        coh_req_v_i[col]    = 1'b1;
        coh_req_op_i[col]   = op;
        coh_req_addr_i[col] = addr;
        coh_req_data_i[col] = data;
        req_cyc      = cycle_r;
        fill_cyc     = 0;
        resp_cyc     = 0;
        mem_cnt      = 0;
        pending_fill = 1'b0;
        got_resp     = 1'b0;

        while (!got_resp)
          begin
            @(negedge core_clk_i);
            coh_req_v_i[col]  = 1'b0;
            mem_resp_v_i[col] = 1'b0;
            if (pending_fill && (cycle_r == fill_due))
              begin
                mem_resp_v_i[col]    = 1'b1;
                mem_resp_data_i[col] = backing_mem[col][addr];
                fill_cyc     = cycle_r;
                pending_fill = 1'b0;
              end
            if (mem_req_v_o[col])
              begin
                mem_cnt++;
                check_addr(col, mem_req_addr_o[col], addr);
                check_op(col, mem_req_op_o[col], op);
                if (op == mc_pkg::e_op_write)
                  begin
                    check_data(col, "memory write data", mem_req_data_o[col], data);
                    backing_mem[col][addr] = data;
                  end
                else
                  begin
                    pending_fill = 1'b1;
                    fill_due     = cycle_r + stim_delay[col][k];
                  end
              end
            if (coh_resp_v_o[col])
              begin
                got_resp = 1'b1;
                resp_cyc = cycle_r;
              end
          end

        exp_mem = ((op == mc_pkg::e_op_write) || !exp_hit) ? 1 : 0;
        if (op == mc_pkg::e_op_read)
          check_hit(col, mem_cnt == 0, exp_hit);
        if (mem_cnt != exp_mem)
          stop_on_error($sformatf(
            "error at time %0t: column %0d sent %0d memory requests, expected %0d",
            $time, col, mem_cnt, exp_mem));

        // hits and writes answer in cycle 2, a fill answers 2 cycles after its return.
        exp_cyc = (exp_mem == 0 || op == mc_pkg::e_op_write) ? req_cyc + 2 : fill_cyc + 2;
        if (resp_cyc != exp_cyc)
          stop_on_error($sformatf(
            "error at time %0t: column %0d responded in cycle %0d, expected %0d",
            $time, col, resp_cyc, exp_cyc));

        if (op == mc_pkg::e_op_write)
          begin
            check_resp(col, coh_resp_op_o[col], mc_pkg::e_resp_ack);
            shadow_mem[col][addr] = data;
            write_cnt++;
          end
        else
          begin
            check_resp(col, coh_resp_op_o[col], mc_pkg::e_resp_data);
            check_data(col, "read data", coh_resp_data_o[col], shadow_mem[col][addr]);
            if (exp_hit)
              hit_cnt++;
            else
              begin
                model_valid[col][idx] = 1'b1;
                model_tag[col][idx]   = tag;
                miss_cnt++;
              end
          end
      end

    @(negedge core_clk_i);
    expect_quiet(col);
  endtask

  // ------------------------------
  // timeout
  // ------------------------------

  always @(posedge core_clk_i)
    begin
      cycle_r <= cycle_r + 1;
      if (cycle_r >= timeout_lp)
        stop_on_error($sformatf("timeout: the run did not finish within %0d cycles", timeout_lp));
    end

  initial
    begin
      void'($urandom(32'h44c2));
      reset_i      = 1'b1;
      coh_req_v_i  = '0;
      mem_resp_v_i = '0;
      for (int c = 0; c < `MC_X_DIM; c++)
        begin
          coh_req_op_i[c]    = mc_pkg::e_op_read;
          coh_req_addr_i[c]  = '0;
          coh_req_data_i[c]  = '0;
          mem_resp_data_i[c] = '0;
          for (int a = 0; a < addr_span_lp; a++)
            begin
              backing_mem[c][a] = fill_word(c, a);
              shadow_mem[c][a]  = fill_word(c, a);
            end
          for (int s = 0; s < `MC_SETS; s++)
            begin
              model_valid[c][s] = 1'b0;
              model_tag[c][s]   = '0;
            end
          for (int k = 0; k < num_reqs_lp; k++)
            begin
              stim_op[c][k]    = ($urandom_range(3, 0) == 0) ? mc_pkg::e_op_write
                                                             : mc_pkg::e_op_read;
              stim_addr[c][k]  = mc_pkg::mc_addr_t'($urandom_range(addr_span_lp - 1, 0));
              stim_data[c][k]  = $urandom;
              stim_delay[c][k] = $urandom_range(8, 1);
            end
        end

      repeat (8) @(posedge core_clk_i);
      @(negedge core_clk_i);
      reset_i = 1'b0;

      // all columns run side by side.
      for (int c = 0; c < `MC_X_DIM; c++)
        begin
          automatic int col = c;
          fork
            run_column(col);
          join_none
        end
      wait fork;

      repeat (4) @(negedge core_clk_i);
      if ((hit_cnt > 0) && (miss_cnt > 0) && (write_cnt > 0))
        begin
          $display("Regression passed");
          $finish;
        end
      else
        stop_on_error($sformatf("traffic missed a case: %0d hits, %0d misses, %0d writes",
                                hit_cnt, miss_cnt, write_cnt));
    end

endmodule
